//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = vec_engine_tb
RTL_TOP    = vec_engine_top
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Testbench failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Simulator exited with an error" >> $(LOG)
	@cat $(LOG)
	@if grep -q -e "$(FAIL_MSG)" -e "exited with an error" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if #(
  parameter int DATA_WIDTH = vec_cfg_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH = vec_mem_pkg::DEF_ADDR_WIDTH
);

  logic                  req_valid;
  logic                  we;
  logic [ADDR_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  req_ready;  // Grant from the arbiter
  logic                  rsp_valid;  // Read data one cycle after accept
  logic [DATA_WIDTH-1:0] rdata;

  modport client (
    output req_valid, we, addr, wdata,
    input  req_ready, rsp_valid, rdata
  );

  modport arbiter (
    input  req_valid, we, addr, wdata,
    output req_ready, rsp_valid, rdata
  );

endinterface

//--- common/vec_cfg_pkg.sv
package vec_cfg_pkg;

  // Element-wise operations of the compute stage
  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    MUL = 2'd2,  // Low half of the product
    MAX = 2'd3   // Unsigned compare
  } vec_op_e;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    COMPUTE = 2'd1,
    DONE    = 2'd2  // Draining the output FIFO
  } vec_state_e;

  localparam int DEF_DATA_WIDTH  = 16;
  localparam int DEF_LENGTH_BITS = 8;  // Vector length field
  localparam int DEF_FIFO_DEPTH  = 4;

endpackage

//--- common/vec_mem_pkg.sv
package vec_mem_pkg;

  // Arbiter client slots, also the round-robin order
  typedef enum logic [1:0] {
    HOST    = 2'd0,
    FETCH_A = 2'd1,
    FETCH_B = 2'd2,
    STORE   = 2'd3
  } mem_client_e;

  localparam int NUM_CLIENTS    = 4;
  localparam int DEF_ADDR_WIDTH = 8;  // Word address

endpackage

//--- dv/vec_engine_props.sv
`timescale 1ns/1ps

module vec_engine_props #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 8
) (
  input logic                                 clk,
  input logic                                 rst_n,
  input logic [vec_mem_pkg::NUM_CLIENTS-1:0] req,
  input logic [vec_mem_pkg::NUM_CLIENTS-1:0] gnt,
  input logic [vec_mem_pkg::NUM_CLIENTS-1:0] we,
  input logic [ADDR_WIDTH-1:0]                addr [vec_mem_pkg::NUM_CLIENTS],
  input logic [DATA_WIDTH-1:0]                wdata [vec_mem_pkg::NUM_CLIENTS],
  input logic [vec_mem_pkg::NUM_CLIENTS-1:0] rsp_valid
);

  import vec_mem_pkg::*;

  // One grant per cycle, only to a requesting client
  one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(gnt) && ((gnt & ~req) == '0) && ((|gnt) == (|req)))
    else $error("grant not given to exactly one requesting client");

  // Response reaches the client whose read was accepted one cycle earlier
  read_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid == $past(req & gnt & ~we))
    else $error("read response not exactly one cycle after the accepted read");

  for (genvar i = 0; i < NUM_CLIENTS; i++) begin : g_hold
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (req[i] && !gnt[i]) |=> (req[i] && $stable(we[i]) && $stable(addr[i])
                               && $stable(wdata[i])))
      else $error("client %0d changed its request before it was accepted", i);
  end

endmodule

bind mem_arbiter vec_engine_props #(
  .DATA_WIDTH(DATA_WIDTH),
  .ADDR_WIDTH(ADDR_WIDTH)
) u_props (
  .clk(clk), .rst_n(rst_n), .req(req), .gnt(gnt), .we(we), .addr(addr),
  .wdata(wdata),
  .rsp_valid({store.rsp_valid, fetch_b.rsp_valid, fetch_a.rsp_valid, host.rsp_valid})
);

//--- dv/vec_engine_tb.sv
`timescale 1ns/1ps

module vec_engine_tb;

  import vec_cfg_pkg::*;
  import vec_mem_pkg::*;

  localparam int DW          = DEF_DATA_WIDTH;
  localparam int AW          = DEF_ADDR_WIDTH;
  localparam int LB          = DEF_LENGTH_BITS;
  localparam int WORDS       = 2 ** AW;
  localparam int REGION      = WORDS / 4;  // A, B, result, spare
  localparam int BASE_A      = 0;
  localparam int BASE_B      = REGION;
  localparam int BASE_R      = 2 * REGION;
  localparam int BASE_S      = 3 * REGION;
  localparam int TOTAL_ELEMS = 4 * 16 + 32 + 1 + REGION;
  localparam int CYCLE_LIMIT = 40 * TOTAL_ELEMS + 2000;

  logic          clk;
  logic          rst_n;
  logic          host_req_valid, host_req_ready, host_we, host_rsp_valid;
  logic [AW-1:0] host_addr;
  logic [DW-1:0] host_wdata, host_rdata;
  logic          start, busy, done;
  vec_op_e       opcode;
  logic [LB-1:0] vec_length;
  logic [AW-1:0] base_a, base_b, base_r;

  logic [DW-1:0] model [WORDS];  // Expected memory image
  logic [15:0]   lfsr_q;
  int            errors;
  int            checks;
  int            done_seen;
  int            cycles;

  vec_engine_top #(
    .DATA_WIDTH(DW), .ADDR_WIDTH(AW), .LENGTH_BITS(LB), .FIFO_DEPTH(DEF_FIFO_DEPTH)
  ) dut (.*);

  always #2 clk = ~clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16 14 13 11
  endfunction

  function automatic logic [DW-1:0] fill_word(input int a);
    logic [AW-1:0] w;
    w = AW'(a);
    return DW'({w, ~w});
  endfunction

  // Expected element from the opcode definitions
  function automatic logic [DW-1:0] ref_op(input vec_op_e op, input logic [DW-1:0] a,
                                           input logic [DW-1:0] b);
    logic [2*DW-1:0] wide;
    case (op)
      ADD:     wide = {{DW{1'b0}}, a} + {{DW{1'b0}}, b};
      SUB:     wide = {{DW{1'b0}}, a} + ((2*DW)'(1) << DW) - {{DW{1'b0}}, b};  // a + 2^DW - b
      MUL:     wide = {{DW{1'b0}}, a} * {{DW{1'b0}}, b};
      default: wide = (a >= b) ? {{DW{1'b0}}, a} : {{DW{1'b0}}, b};
    endcase
    return wide[DW-1:0];  // Modulo 2^DW
  endfunction

  task automatic rand_word(output logic [DW-1:0] w);
    for (int i = 0; i < DW; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w[i]   = lfsr_q[0];
    end
  endtask

  task automatic check_val(input string name, input logic [DW-1:0] got,
                           input logic [DW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic wait_grant();
    #1;
    while (!host_req_ready) begin
      @(negedge clk);
      #1;
    end
  endtask

  task automatic host_write(input int addr, input logic [DW-1:0] data);
    @(negedge clk);
    host_req_valid = 1'b1;
    host_we        = 1'b1;
    host_addr      = AW'(addr);
    host_wdata     = data;
    wait_grant();
    @(negedge clk);  // Accepted at the edge before
    host_req_valid = 1'b0;
    model[addr]    = data;
  endtask

  task automatic host_read(input int addr, output logic [DW-1:0] data);
    @(negedge clk);
    host_req_valid = 1'b1;
    host_we        = 1'b0;
    host_addr      = AW'(addr);
    wait_grant();
    @(negedge clk);
    host_req_valid = 1'b0;
    if (!host_rsp_valid) begin
      errors++;
      $display("Read of address %0d got no response at %0t", addr, $time);
    end
    data = host_rdata;
  endtask

  task automatic check_words(input string label, input int base, input int count);
    logic [DW-1:0] got;
    for (int i = 0; i < count; i++) begin
      host_read(base + i, got);
      check_val($sformatf("%s[%0d]", label, i), got, model[base + i]);
    end
  endtask

  task automatic load_operands(input vec_op_e op, input int len);
    logic [DW-1:0] a;
    logic [DW-1:0] b;
    for (int i = 0; i < len; i++) begin
      rand_word(a);
      rand_word(b);
      if (op == SUB && i % 4 != 0) begin
        a[DW-1] = 1'b0;  // B above A, result wraps
        b[DW-1] = 1'b1;
      end
      if (op == MAX && i % 3 == 0) b = a;
      host_write(BASE_A + i, a);
      host_write(BASE_B + i, b);
    end
  endtask

  task automatic apply_ref(input vec_op_e op, input int len, input int br);
    for (int i = 0; i < len; i++) begin
      model[br + i] = ref_op(op, model[BASE_A + i], model[BASE_B + i]);
    end
  endtask

  task automatic start_op(input vec_op_e op, input int len, input int br);
    @(negedge clk);
    start      = 1'b1;
    opcode     = op;
    vec_length = LB'(len);
    base_a     = AW'(BASE_A);
    base_b     = AW'(BASE_B);
    base_r     = AW'(br);
    @(negedge clk);
    start = 1'b0;
    check_val("busy", DW'(busy), DW'(1));
  endtask

  task automatic wait_done(input int d0, input int len);
    int n;
    n = 0;
    while (done_seen == d0 && n < 40 * len + 200) begin
      @(negedge clk);
      n++;
    end
    if (done_seen == d0) begin
      errors++;
      $display("Operation of length %0d never finished, no done pulse by %0t", len, $time);
    end else begin
      check_val("busy", DW'(busy), '0);  // Cleared the cycle after done
    end
  endtask

  task automatic run_vec(input vec_op_e op, input int len);
    int d0;
    load_operands(op, len);
    d0 = done_seen;
    start_op(op, len, BASE_R);
    wait_done(d0, len);
    apply_ref(op, len, BASE_R);
    check_words("result", BASE_R, len);
    check_words("guard", BASE_R + len, 1);
  endtask

  task automatic busy_port_test();
    int d0;
    load_operands(ADD, 32);
    d0 = done_seen;
    start_op(ADD, 32, BASE_R);
    fork
      wait_done(d0, 32);
      begin
        start_op(SUB, 16, BASE_S);  // Arrives while busy
        check_words("host_a", BASE_A, 32);
        check_words("host_b", BASE_B, 32);
      end
    join
    repeat (4) @(negedge clk);
    check_val("done_pulses", DW'(done_seen - d0), DW'(1));
    apply_ref(ADD, 32, BASE_R);
    check_words("result", BASE_R, 32);
    check_words("spare", BASE_S, 16);
  endtask

  task automatic back_to_back_test();
    int d0;
    load_operands(ADD, REGION);
    d0 = done_seen;
    start_op(SUB, 1, BASE_S);
    wait_done(d0, 1);
    start_op(ADD, REGION, BASE_R);  // Largest length per region
    check_val("done_pulses", DW'(done_seen - d0), DW'(1));
    wait_done(d0 + 1, REGION);
    repeat (4) @(negedge clk);
    check_val("done_pulses", DW'(done_seen - d0), DW'(2));
    apply_ref(SUB, 1, BASE_S);
    apply_ref(ADD, REGION, BASE_R);
    check_words("result", BASE_R, REGION);
    check_words("guard", BASE_S, 2);
  endtask

  initial begin
    done_seen = 0;
    forever begin
      @(negedge clk);
      #1;
      if (done) done_seen++;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the tests did not complete", cycles);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    errors         = 0;
    checks         = 0;
    lfsr_q         = 16'd25;
    clk            = 1'b0;
    rst_n          = 1'b0;
    host_req_valid = 1'b0;
    host_we        = 1'b0;
    host_addr      = '0;
    host_wdata     = '0;
    start          = 1'b0;
    opcode         = ADD;
    vec_length     = '0;
    base_a         = '0;
    base_b         = '0;
    base_r         = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_val("busy", DW'(busy), '0);
    check_val("done", DW'(done), '0);
    check_val("host_req_ready", DW'(host_req_ready), '0);
    check_val("host_rsp_valid", DW'(host_rsp_valid), '0);
    for (int a = 0; a < WORDS; a++) host_write(a, fill_word(a));
    run_vec(ADD, 16);
    run_vec(SUB, 16);
    run_vec(MUL, 16);
    run_vec(MAX, 16);
    busy_port_test();
    back_to_back_test();
    check_words("mem", 0, WORDS);  // Nothing written outside the regions
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int DATA_WIDTH = vec_cfg_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH = vec_mem_pkg::DEF_ADDR_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  mem_req_if.arbiter            host,
  mem_req_if.arbiter            fetch_a,
  mem_req_if.arbiter            fetch_b,
  mem_req_if.arbiter            store,
  output logic                  mem_en,
  output logic                  mem_we,
  output logic [ADDR_WIDTH-1:0] mem_addr,
  output logic [DATA_WIDTH-1:0] mem_wdata,
  input  logic [DATA_WIDTH-1:0] mem_rdata
);

  import vec_mem_pkg::*;

  logic [NUM_CLIENTS-1:0] req;
  logic [NUM_CLIENTS-1:0] we;
  logic [NUM_CLIENTS-1:0] gnt;
  logic [ADDR_WIDTH-1:0]  addr  [NUM_CLIENTS];
  logic [DATA_WIDTH-1:0]  wdata [NUM_CLIENTS];
  mem_client_e            last_q, gnt_idx;
  logic                   rsp_pend_q;  // Read granted last cycle
  mem_client_e            rsp_idx_q;

  assign req[HOST]     = host.req_valid;
  assign req[FETCH_A]  = fetch_a.req_valid;
  assign req[FETCH_B]  = fetch_b.req_valid;
  assign req[STORE]    = store.req_valid;
  assign we[HOST]      = host.we;
  assign we[FETCH_A]   = fetch_a.we;
  assign we[FETCH_B]   = fetch_b.we;
  assign we[STORE]     = store.we;
  assign addr[HOST]    = host.addr;
  assign addr[FETCH_A] = fetch_a.addr;
  assign addr[FETCH_B] = fetch_b.addr;
  assign addr[STORE]   = store.addr;
  assign wdata[HOST]    = host.wdata;
  assign wdata[FETCH_A] = fetch_a.wdata;
  assign wdata[FETCH_B] = fetch_b.wdata;
  assign wdata[STORE]   = store.wdata;

  // Nearest requester after the last grant wins
  always_comb begin
    logic [1:0] cand;
    gnt_idx = last_q;
    gnt     = '0;
    for (int i = NUM_CLIENTS; i >= 1; i--) begin
      cand = 2'(last_q) + 2'(i);
      if (req[cand]) gnt_idx = mem_client_e'(cand);
    end
    if (|req) gnt[gnt_idx] = 1'b1;
  end

  assign mem_en    = |req;
  assign mem_we    = we[gnt_idx];
  assign mem_addr  = addr[gnt_idx];
  assign mem_wdata = wdata[gnt_idx];

  assign host.req_ready    = gnt[HOST];
  assign fetch_a.req_ready = gnt[FETCH_A];
  assign fetch_b.req_ready = gnt[FETCH_B];
  assign store.req_ready   = gnt[STORE];

  assign host.rsp_valid    = rsp_pend_q && (rsp_idx_q == HOST);
  assign fetch_a.rsp_valid = rsp_pend_q && (rsp_idx_q == FETCH_A);
  assign fetch_b.rsp_valid = rsp_pend_q && (rsp_idx_q == FETCH_B);
  assign store.rsp_valid   = rsp_pend_q && (rsp_idx_q == STORE);

  assign host.rdata    = mem_rdata;
  assign fetch_a.rdata = mem_rdata;
  assign fetch_b.rdata = mem_rdata;
  assign store.rdata   = mem_rdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q     <= STORE;  // Host first after reset
      rsp_pend_q <= 1'b0;
      rsp_idx_q  <= HOST;
    end else begin
      if (mem_en) last_q <= gnt_idx;
      rsp_pend_q <= mem_en && !mem_we;
      rsp_idx_q  <= gnt_idx;
    end
  end

endmodule

//--- rtl/scratchpad_mem.sv
`timescale 1ns/1ps

module scratchpad_mem #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  en,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  logic [DATA_WIDTH-1:0] wdata,
  output logic [DATA_WIDTH-1:0] rdata
);

  logic [DATA_WIDTH-1:0] ram [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        ram[addr] <= wdata;
      end else begin
        rdata <= ram[addr];  // Valid on the next cycle
      end
    end
  end

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int DATA_WIDTH = 16,
  parameter int DEPTH      = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  logic                  rd_en,
  input  logic [DATA_WIDTH-1:0] wdata,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic                  full,
  output logic                  empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_WIDTH-1:0] buf_q [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  do_wr;
  logic                  do_rd;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;  // Wraps for any depth
  endfunction

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;
  assign rdata = buf_q[rd_ptr];  // Head entry, no read needed

  always_ff @(posedge clk) begin
    if (do_wr) begin
      buf_q[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
      if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push with pop
      endcase
    end
  end

endmodule

//--- rtl/vec_engine_top.sv
`timescale 1ns/1ps

module vec_engine_top #(
  parameter int DATA_WIDTH  = vec_cfg_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH  = vec_mem_pkg::DEF_ADDR_WIDTH,
  parameter int LENGTH_BITS = vec_cfg_pkg::DEF_LENGTH_BITS,
  parameter int FIFO_DEPTH  = vec_cfg_pkg::DEF_FIFO_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   host_req_valid,
  output logic                   host_req_ready,
  input  logic                   host_we,
  input  logic [ADDR_WIDTH-1:0]  host_addr,
  input  logic [DATA_WIDTH-1:0]  host_wdata,
  output logic                   host_rsp_valid,
  output logic [DATA_WIDTH-1:0]  host_rdata,
  input  logic                   start,
  input  vec_cfg_pkg::vec_op_e   opcode,
  input  logic [LENGTH_BITS-1:0] vec_length,
  input  logic [ADDR_WIDTH-1:0]  base_a,
  input  logic [ADDR_WIDTH-1:0]  base_b,
  input  logic [ADDR_WIDTH-1:0]  base_r,
  output logic                   busy,
  output logic                   done
);

  logic                  start_acc;  // Start seen while not busy
  logic                  a_valid, a_ready, b_valid, b_ready, r_valid, r_ready;
  logic [DATA_WIDTH-1:0] a_data, b_data, r_data;
  logic                  mem_en, mem_we;
  logic [ADDR_WIDTH-1:0] mem_addr;
  logic [DATA_WIDTH-1:0] mem_wdata, mem_rdata;

  mem_req_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) host_if ();
  mem_req_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) fa_if ();
  mem_req_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) fb_if ();
  mem_req_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) st_if ();

  assign start_acc = start && !busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (start_acc) begin
      busy <= 1'b1;
    end else if (done) begin
      busy <= 1'b0;  // Falls the cycle after the done pulse
    end
  end

  assign host_if.req_valid = host_req_valid;
  assign host_if.we        = host_we;
  assign host_if.addr      = host_addr;
  assign host_if.wdata     = host_wdata;
  assign host_req_ready    = host_if.req_ready;
  assign host_rsp_valid    = host_if.rsp_valid;
  assign host_rdata        = host_if.rdata;

  operand_fetch #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .LENGTH_BITS(LENGTH_BITS)
  ) u_fetch_a (
    .clk(clk), .rst_n(rst_n), .start(start_acc), .base_addr(base_a),
    .vec_length(vec_length), .out_ready(a_ready), .mem(fa_if),
    .out_valid(a_valid), .out_data(a_data)
  );

  operand_fetch #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .LENGTH_BITS(LENGTH_BITS)
  ) u_fetch_b (
    .clk(clk), .rst_n(rst_n), .start(start_acc), .base_addr(base_b),
    .vec_length(vec_length), .out_ready(b_ready), .mem(fb_if),
    .out_valid(b_valid), .out_data(b_data)
  );

  vctr_stream_alu #(
    .DATA_WIDTH(DATA_WIDTH), .LENGTH_BITS(LENGTH_BITS), .FIFO_DEPTH(FIFO_DEPTH)
  ) u_alu (
    .clk(clk), .rst_n(rst_n), .start(start_acc), .opcode(opcode),
    .vec_length(vec_length),
    .in_a_valid(a_valid), .in_a_data(a_data), .in_b_valid(b_valid), .in_b_data(b_data),
    .out_ready(r_ready), .in_a_ready(a_ready), .in_b_ready(b_ready),
    .out_valid(r_valid), .out_data(r_data), .idle()
  );

  result_store #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .LENGTH_BITS(LENGTH_BITS)
  ) u_store (
    .clk(clk), .rst_n(rst_n), .start(start_acc), .base_addr(base_r),
    .vec_length(vec_length), .in_valid(r_valid), .in_data(r_data),
    .in_ready(r_ready), .mem(st_if), .done(done)
  );

  mem_arbiter #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_arb (
    .clk(clk), .rst_n(rst_n),
    .host(host_if), .fetch_a(fa_if), .fetch_b(fb_if), .store(st_if),
    .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

  scratchpad_mem #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_mem (
    .clk(clk), .en(mem_en), .we(mem_we), .addr(mem_addr),
    .wdata(mem_wdata), .rdata(mem_rdata)
  );

endmodule

//--- vctr_stream/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch #(
  parameter int DATA_WIDTH  = vec_cfg_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH  = vec_mem_pkg::DEF_ADDR_WIDTH,
  parameter int LENGTH_BITS = vec_cfg_pkg::DEF_LENGTH_BITS
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic [ADDR_WIDTH-1:0]  base_addr,
  input  logic [LENGTH_BITS-1:0] vec_length,
  input  logic                   out_ready,
  mem_req_if.client              mem,
  output logic                   out_valid,
  output logic [DATA_WIDTH-1:0]  out_data
);

  logic [ADDR_WIDTH-1:0]  addr_q;
  logic [LENGTH_BITS-1:0] left_q;  // Reads still to issue
  logic                   pend_q;  // One read in flight
  logic                   accept;

  // Ready at issue stays high, only this fetcher fills the FIFO
  assign mem.req_valid = (left_q != '0) && !pend_q && out_ready;
  assign mem.we        = 1'b0;
  assign mem.addr      = addr_q;
  assign mem.wdata     = '0;
  assign accept        = mem.req_valid && mem.req_ready;

  assign out_valid = mem.rsp_valid;
  assign out_data  = mem.rdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
      left_q <= '0;
      pend_q <= 1'b0;
    end else begin
      if (start) begin
        addr_q <= base_addr;
        left_q <= vec_length;
      end else if (accept) begin
        addr_q <= addr_q + 1'b1;
        left_q <= left_q - 1'b1;
      end
      if (accept) begin
        pend_q <= 1'b1;
      end else if (mem.rsp_valid) begin
        pend_q <= 1'b0;
      end
    end
  end

endmodule

//--- vctr_stream/result_store.sv
`timescale 1ns/1ps

module result_store #(
  parameter int DATA_WIDTH  = vec_cfg_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH  = vec_mem_pkg::DEF_ADDR_WIDTH,
  parameter int LENGTH_BITS = vec_cfg_pkg::DEF_LENGTH_BITS
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic [ADDR_WIDTH-1:0]  base_addr,
  input  logic [LENGTH_BITS-1:0] vec_length,
  input  logic                   in_valid,
  input  logic [DATA_WIDTH-1:0]  in_data,
  output logic                   in_ready,
  mem_req_if.client              mem,
  output logic                   done
);

  logic [ADDR_WIDTH-1:0]  addr_q;
  logic [DATA_WIDTH-1:0]  data_q;
  logic [LENGTH_BITS-1:0] left_q;  // Elements still to take
  logic                   pend_q;  // Write waiting for grant
  logic                   wr_acc;
  logic                   take;

  assign wr_acc   = pend_q && mem.req_ready;
  assign in_ready = (left_q != '0) && (!pend_q || mem.req_ready);
  assign take     = in_valid && in_ready;
  assign done     = wr_acc && (left_q == '0);  // Last write granted

  assign mem.req_valid = pend_q;
  assign mem.we        = 1'b1;
  assign mem.addr      = addr_q;
  assign mem.wdata     = data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
      left_q <= '0;
      pend_q <= 1'b0;
    end else begin
      if (start) begin
        addr_q <= base_addr;
        left_q <= vec_length;
      end else begin
        if (wr_acc) addr_q <= addr_q + 1'b1;
        if (take) left_q <= left_q - 1'b1;
      end
      if (take) begin
        pend_q <= 1'b1;
      end else if (wr_acc) begin
        pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) data_q <= in_data;
  end

endmodule

//--- vctr_stream/vctr_stream_alu.sv
`timescale 1ns/1ps

module vctr_stream_alu #(
  parameter int DATA_WIDTH  = vec_cfg_pkg::DEF_DATA_WIDTH,
  parameter int LENGTH_BITS = vec_cfg_pkg::DEF_LENGTH_BITS,
  parameter int FIFO_DEPTH  = vec_cfg_pkg::DEF_FIFO_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  vec_cfg_pkg::vec_op_e   opcode,
  input  logic [LENGTH_BITS-1:0] vec_length,
  input  logic                   in_a_valid,
  input  logic [DATA_WIDTH-1:0]  in_a_data,
  input  logic                   in_b_valid,
  input  logic [DATA_WIDTH-1:0]  in_b_data,
  input  logic                   out_ready,
  output logic                   in_a_ready,
  output logic                   in_b_ready,
  output logic                   out_valid,
  output logic [DATA_WIDTH-1:0]  out_data,
  output logic                   idle
);

  import vec_cfg_pkg::*;

  vec_state_e             state_q, state_d;
  vec_op_e                op_q;
  logic [LENGTH_BITS-1:0] len_q;
  logic [LENGTH_BITS-1:0] count_q;  // Results pushed so far

  logic                  a_full, a_empty, b_full, b_empty;
  logic [DATA_WIDTH-1:0] a_head, b_head;
  logic                  out_full, out_empty;

  logic                  s1_valid, s2_valid;
  logic [DATA_WIDTH-1:0] s1_a, s1_b;
  logic [DATA_WIDTH-1:0] s2_data, alu_res;
  logic                  s1_adv, s2_adv, pop, push;

  assign in_a_ready = (state_q == COMPUTE) && !a_full;
  assign in_b_ready = (state_q == COMPUTE) && !b_full;
  assign out_valid  = !out_empty;
  assign idle       = (state_q == IDLE);

  assign push   = s2_valid && !out_full;
  assign s2_adv = !s2_valid || !out_full;   // Stage 2 empty or leaving
  assign s1_adv = !s1_valid || s2_adv;
  assign pop    = (state_q == COMPUTE) && !a_empty && !b_empty && s1_adv;

  always_comb begin
    case (op_q)
      ADD:     alu_res = s1_a + s1_b;
      SUB:     alu_res = s1_a - s1_b;   // Wraps modulo 2^DATA_WIDTH
      MUL:     alu_res = s1_a * s1_b;   // Low half kept
      MAX:     alu_res = (s1_a > s1_b) ? s1_a : s1_b;
      default: alu_res = s1_a;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start) state_d = COMPUTE;
      COMPUTE: if (count_q == len_q) state_d = DONE;
      DONE:    if (out_empty) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      op_q     <= ADD;
      len_q    <= '0;
      count_q  <= '0;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && start) begin
        op_q    <= opcode;
        len_q   <= vec_length;
        count_q <= '0;
      end else if (push) begin
        count_q <= count_q + 1'b1;
      end
      if (s1_adv) s1_valid <= pop;
      if (s2_adv) s2_valid <= s1_valid;
    end
  end

  // Operand and result registers
  always_ff @(posedge clk) begin
    if (s1_adv) begin
      s1_a <= a_head;
      s1_b <= b_head;
    end
    if (s2_adv) s2_data <= alu_res;
  end

  sync_fifo #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(FIFO_DEPTH)) u_fifo_a (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (in_a_valid && in_a_ready),
    .rd_en (pop),
    .wdata (in_a_data),
    .rdata (a_head),
    .full  (a_full),
    .empty (a_empty)
  );

  sync_fifo #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(FIFO_DEPTH)) u_fifo_b (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (in_b_valid && in_b_ready),
    .rd_en (pop),
    .wdata (in_b_data),
    .rdata (b_head),
    .full  (b_full),
    .empty (b_empty)
  );

  sync_fifo #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(FIFO_DEPTH)) u_fifo_out (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (push),
    .rd_en (out_valid && out_ready),  // Drained by the result store
    .wdata (s2_data),
    .rdata (out_data),
    .full  (out_full),
    .empty (out_empty)
  );

endmodule

//--- verilog.f
common/vec_cfg_pkg.sv
common/vec_mem_pkg.sv
common/mem_req_if.sv
rtl/sync_fifo.sv
vctr_stream/vctr_stream_alu.sv
vctr_stream/operand_fetch.sv
vctr_stream/result_store.sv
rtl/mem_arbiter.sv
rtl/scratchpad_mem.sv
rtl/vec_engine_top.sv
dv/vec_engine_props.sv
dv/vec_engine_tb.sv
